// ==== hw/fpu_short_pkg.sv ====
package fpu_short_pkg;

    // register word and instruction fields
    typedef logic [31:0] word_t;
    typedef logic [2:0]  func3_t;
    typedef logic [6:0]  func7_t;

    // single precision fields
    typedef logic [7:0]  exp_t;
    typedef logic [22:0] frac_t;

    // func7 encodings of the short operations
    localparam func7_t FUNC7_FSGNJ = 7'b0010000;
    localparam func7_t FUNC7_FCOMP = 7'b1010000;
    localparam func7_t FUNC7_FTOI  = 7'b1100000;
    localparam func7_t FUNC7_ITOF  = 7'b1101000;
    localparam func7_t FUNC7_FMVI  = 7'b1110000;
    localparam func7_t FUNC7_IMVF  = 7'b1111000;
    localparam func7_t FUNC7_FRM   = 7'b0100100;

    // func3 encodings within a func7 group
    localparam func3_t FUNC3_FSGNJ  = 3'b000;
    localparam func3_t FUNC3_FSGNJN = 3'b001;
    localparam func3_t FUNC3_FSGNJX = 3'b010;
    localparam func3_t FUNC3_FEQ    = 3'b010;
    localparam func3_t FUNC3_FLT    = 3'b001;
    localparam func3_t FUNC3_FLE    = 3'b000;
    localparam func3_t FUNC3_FFLOOR = 3'b010;

    typedef enum logic [3:0] {
        OP_FSGNJ,
        OP_FSGNJN,
        OP_FSGNJX,
        OP_FEQ,
        OP_FLT,
        OP_FLE,
        OP_ITOF,
        OP_FTOI,
        OP_FFLOOR,
        OP_FMVI,
        OP_IMVF,
        OP_ERROR
    } fpu_op_t;

    // stage 1 register, decode to execute
    typedef struct packed {
        fpu_op_t op;
        word_t   rs1;
        word_t   rs2;
        logic    valid;
    } fpu_slot_t;

endpackage

// ==== hw/fpu_short_decode.sv ====
`timescale 1ns/10ps

module fpu_short_decode import fpu_short_pkg::*; #(
    parameter int PREG_ADDR_W = 6
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   order,
    input  func3_t                 func3,
    input  func7_t                 func7,
    input  word_t                  rs1,
    input  word_t                  rs2,
    input  logic [PREG_ADDR_W-1:0] pa_rd_in,
    output fpu_slot_t              slot,
    output logic [PREG_ADDR_W-1:0] slot_tag
);

    fpu_op_t op;
    fpu_op_t op_q;
    word_t   rs1_q;
    word_t   rs2_q;
    logic    valid_q;

    // func7 picks the group, func3 the member
    always_comb begin
        op = OP_ERROR;
        case (func7)
            FUNC7_FSGNJ: begin
                case (func3)
                    FUNC3_FSGNJ:  op = OP_FSGNJ;
                    FUNC3_FSGNJN: op = OP_FSGNJN;
                    FUNC3_FSGNJX: op = OP_FSGNJX;
                    default:      op = OP_ERROR;
                endcase
            end
            FUNC7_FCOMP: begin
                case (func3)
                    FUNC3_FEQ: op = OP_FEQ;
                    FUNC3_FLT: op = OP_FLT;
                    FUNC3_FLE: op = OP_FLE;
                    default:   op = OP_ERROR;
                endcase
            end
            // only the floor mode is implemented
            FUNC7_FRM:  op = (func3 == FUNC3_FFLOOR) ? OP_FFLOOR : OP_ERROR;
            FUNC7_ITOF: op = OP_ITOF;
            FUNC7_FTOI: op = OP_FTOI;
            FUNC7_FMVI: op = OP_FMVI;
            FUNC7_IMVF: op = OP_IMVF;
            default:    op = OP_ERROR;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= order;
        end
    end

    // operands and tag only load on an order
    always_ff @(posedge clk) begin
        if (order) begin
            op_q     <= op;
            rs1_q    <= rs1;
            rs2_q    <= rs2;
            slot_tag <= pa_rd_in;
        end
    end

    assign slot = '{op: op_q, rs1: rs1_q, rs2: rs2_q, valid: valid_q};

endmodule

// ==== hw/fpu_sign_compare.sv ====
`timescale 1ns/10ps

module fpu_sign_compare import fpu_short_pkg::*; (
    input  fpu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    logic  a_nan;
    logic  b_nan;
    logic  unordered;
    word_t fa;
    word_t fb;
    logic  is_eq;
    logic  is_lt;

    assign a_nan = (a[30:23] == 8'hff) && (a[22:0] != '0);
    assign b_nan = (b[30:23] == 8'hff) && (b[22:0] != '0);
    assign unordered = a_nan | b_nan;

    // zero and subnormal both become +0, so -0 == +0
    assign fa = (a[30:23] == 8'h00) ? '0 : a;
    assign fb = (b[30:23] == 8'h00) ? '0 : b;

    assign is_eq = (fa == fb);

    // sign first, then magnitude, reversed when both negative
    always_comb begin
        if (fa[31] != fb[31]) begin
            is_lt = fa[31];
        end else if (fa[31]) begin
            is_lt = fa[30:0] > fb[30:0];
        end else begin
            is_lt = fa[30:0] < fb[30:0];
        end
    end

    always_comb begin
        case (op)
            OP_FSGNJ:  result = {b[31], a[30:0]};
            OP_FSGNJN: result = {~b[31], a[30:0]};
            OP_FSGNJX: result = {a[31] ^ b[31], a[30:0]};
            OP_FEQ:    result = {31'b0, ~unordered & is_eq};
            OP_FLT:    result = {31'b0, ~unordered & is_lt};
            OP_FLE:    result = {31'b0, ~unordered & (is_lt | is_eq)};
            default:   result = '0;
        endcase
    end

endmodule

// ==== hw/fpu_convert.sv ====
`timescale 1ns/10ps

module fpu_convert import fpu_short_pkg::*; (
    input  fpu_op_t op,
    input  word_t   a,
    output word_t   result
);

    localparam exp_t EXP_BIAS = 8'd127;

    // itof
    word_t       i_mag;
    logic [4:0]  i_lz;
    word_t       i_norm;
    logic        i_round;
    logic [23:0] i_frac_rnd;
    exp_t        i_exp;
    word_t       itof_res;

    // ftoi
    exp_t        a_exp;
    frac_t       a_frac;
    logic        a_nan;
    word_t       t_sig;
    exp_t        t_shift;
    word_t       t_mag;
    word_t       ftoi_res;

    // ffloor
    frac_t       f_mask;
    logic [4:0]  f_bits;
    word_t       f_cut;
    word_t       ffloor_res;

    assign a_exp  = a[30:23];
    assign a_frac = a[22:0];
    assign a_nan  = (a_exp == 8'hff) && (a_frac != '0);

    // absolute value, -2^31 stays 0x80000000 as unsigned
    assign i_mag = a[31] ? -a : a;

    // leading zero count, highest set bit wins
    always_comb begin
        i_lz = 5'd0;
        for (int i = 0; i < 32; i++) begin
            if (i_mag[i]) begin
                i_lz = 5'(31 - i);
            end
        end
    end

    assign i_norm = i_mag << i_lz;

    // round to nearest even on guard and sticky
    assign i_round    = i_norm[7] & ((|i_norm[6:0]) | i_norm[8]);
    assign i_frac_rnd = {1'b0, i_norm[30:8]} + {23'b0, i_round};
    assign i_exp      = 8'd158 - {3'b0, i_lz} + {7'b0, i_frac_rnd[23]};

    assign itof_res = (i_mag == '0) ? '0 : {a[31], i_exp, i_frac_rnd[22:0]};

    // unbiased exponent is 0..30 in the shifting range
    assign t_sig   = {8'b0, 1'b1, a_frac};
    assign t_shift = a_exp - EXP_BIAS;
    assign t_mag   = (t_shift >= 8'd23) ? (t_sig << (t_shift - 8'd23))
                                        : (t_sig >> (8'd23 - t_shift));

    always_comb begin
        if (a_nan) begin
            ftoi_res = 32'h7fffffff;
        end else if (a_exp >= 8'd158) begin
            // out of range saturates by sign
            ftoi_res = a[31] ? 32'h80000000 : 32'h7fffffff;
        end else if (a_exp < EXP_BIAS) begin
            ftoi_res = '0;
        end else begin
            ftoi_res = a[31] ? -t_mag : t_mag;
        end
    end

    // fraction bits below the binary point
    assign f_mask = 23'h7fffff >> (a_exp - EXP_BIAS);
    assign f_bits = 5'(8'd150 - a_exp);
    assign f_cut  = a & ~{9'b0, f_mask};

    always_comb begin
        if (a_exp >= 8'd150) begin
            // already integral, or inf and nan
            ffloor_res = a;
        end else if (a_exp == 8'h00) begin
            ffloor_res = {a[31], 31'b0};
        end else if (a_exp < EXP_BIAS) begin
            ffloor_res = a[31] ? 32'hbf800000 : '0;
        end else if (a[31] && ((a_frac & f_mask) != '0)) begin
            // carry may run into the exponent
            ffloor_res = f_cut + (32'd1 << f_bits);
        end else begin
            ffloor_res = f_cut;
        end
    end

    always_comb begin
        case (op)
            OP_ITOF:   result = itof_res;
            OP_FTOI:   result = ftoi_res;
            OP_FFLOOR: result = ffloor_res;
            default:   result = '0;
        endcase
    end

endmodule

// ==== hw/fpu_short_execute.sv ====
`timescale 1ns/10ps

module fpu_short_execute import fpu_short_pkg::*; #(
    parameter int PREG_ADDR_W = 6
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  fpu_slot_t              slot,
    input  logic [PREG_ADDR_W-1:0] slot_tag,
    output logic                   done,
    output word_t                  rd,
    output logic [PREG_ADDR_W-1:0] pa_rd_out
);

    word_t sc_result;
    word_t cv_result;
    word_t sel_result;

    fpu_sign_compare u_sign_compare (
        .op     (slot.op),
        .a      (slot.rs1),
        .b      (slot.rs2),
        .result (sc_result)
    );

    fpu_convert u_convert (
        .op     (slot.op),
        .a      (slot.rs1),
        .result (cv_result)
    );

    always_comb begin
        case (slot.op)
            OP_FSGNJ, OP_FSGNJN, OP_FSGNJX,
            OP_FEQ, OP_FLT, OP_FLE:       sel_result = sc_result;
            OP_ITOF, OP_FTOI, OP_FFLOOR:  sel_result = cv_result;
            // raw moves pass rs1 through
            OP_FMVI, OP_IMVF:             sel_result = slot.rs1;
            default:                      sel_result = '0;
        endcase
    end

    // rd held at zero between results
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
            rd   <= '0;
        end else begin
            done <= slot.valid;
            rd   <= slot.valid ? sel_result : '0;
        end
    end

    always_ff @(posedge clk) begin
        pa_rd_out <= slot_tag;
    end

endmodule

// ==== hw/fpu_short.sv ====
`timescale 1ns/10ps

module fpu_short import fpu_short_pkg::*; #(
    parameter int PREG_ADDR_W = 6
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   order,
    input  func3_t                 func3,
    input  func7_t                 func7,
    input  word_t                  rs1,
    input  word_t                  rs2,
    input  logic [PREG_ADDR_W-1:0] pa_rd_in,
    output logic                   done,
    output word_t                  rd,
    output logic [PREG_ADDR_W-1:0] pa_rd_out
);

    // stage 1 to stage 2
    fpu_slot_t              slot;
    logic [PREG_ADDR_W-1:0] slot_tag;

    fpu_short_decode #(
        .PREG_ADDR_W (PREG_ADDR_W)
    ) u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .order    (order),
        .func3    (func3),
        .func7    (func7),
        .rs1      (rs1),
        .rs2      (rs2),
        .pa_rd_in (pa_rd_in),
        .slot     (slot),
        .slot_tag (slot_tag)
    );

    fpu_short_execute #(
        .PREG_ADDR_W (PREG_ADDR_W)
    ) u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .slot      (slot),
        .slot_tag  (slot_tag),
        .done      (done),
        .rd        (rd),
        .pa_rd_out (pa_rd_out)
    );

endmodule

// ==== sim/fpu_short_assert.sv ====
`timescale 1ns/10ps

module fpu_short_assert import fpu_short_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  order,
    input logic  done,
    input word_t rd
);

    // nothing leaves the pipeline while reset is held
    done_in_reset: assert property (@(posedge clk) !rst_n |-> !done)
        else $error("done high during reset");

    // fixed latency of two stages, checked both ways
    order_to_done: assert property (@(posedge clk) disable iff (!rst_n) order |-> ##2 done)
        else $error("order not followed by done two cycles later");

    done_from_order: assert property (@(posedge clk) disable iff (!rst_n)
                                      done |-> $past(order, 2))
        else $error("done without an order two cycles earlier");

    rd_idle_zero: assert property (@(posedge clk) disable iff (!rst_n) !done |-> rd == '0)
        else $error("rd nonzero while done is low");

endmodule

bind fpu_short fpu_short_assert u_assert (
    .clk   (clk),
    .rst_n (rst_n),
    .order (order),
    .done  (done),
    .rd    (rd)
);

// ==== sim/fpu_short_tb.sv ====
`timescale 1ns/10ps

module fpu_short_tb;

    localparam int          TAG_W = 6;
    localparam logic [31:0] SEED  = 32'h87d03e12;

    // instruction encodings, {func7, func3}
    localparam logic [6:0] F7_FSGNJ  = 7'b0010000;
    localparam logic [6:0] F7_FCOMP  = 7'b1010000;
    localparam logic [6:0] F7_FTOI   = 7'b1100000;
    localparam logic [6:0] F7_ITOF   = 7'b1101000;
    localparam logic [6:0] F7_FMVI   = 7'b1110000;
    localparam logic [6:0] F7_IMVF   = 7'b1111000;
    localparam logic [6:0] F7_FRM    = 7'b0100100;
    localparam logic [2:0] F3_FFLOOR = 3'b010;
    localparam logic [9:0] OP_CODE [11] = '{
        {F7_FSGNJ, 3'b000}, {F7_FSGNJ, 3'b001}, {F7_FSGNJ, 3'b010},
        {F7_FCOMP, 3'b010}, {F7_FCOMP, 3'b001}, {F7_FCOMP, 3'b000},
        {F7_ITOF, 3'b000}, {F7_FTOI, 3'b000}, {F7_FRM, F3_FFLOOR},
        {F7_FMVI, 3'b000}, {F7_IMVF, 3'b000}
    };

    // zeros, halves, range edges, infinities, nans, subnormals
    localparam logic [31:0] SPECIAL [16] = '{
        32'h00000000, 32'h80000000, 32'h3f000000, 32'hbf000000,
        32'hbfc00000, 32'h4f000000, 32'hcf000000, 32'h5f000000,
        32'h7f800000, 32'hff800000, 32'h7fc00000, 32'hffc00001,
        32'h4b000001, 32'hc0490fdb, 32'h00400000, 32'h3f800000
    };
    localparam logic [31:0] INT_SPECIAL [6] = '{
        32'h00000000, 32'hffffffff, 32'h01000001,
        32'h7fffffff, 32'h80000000, 32'h01000003
    };

    localparam int N_RAND      = 12;
    localparam int N_B2B       = 64;
    localparam int TOTAL_OPS   = 13 * N_RAND + 191 + N_B2B;
    localparam int WATCHDOG_NS = (TOTAL_OPS + 100) * 10;

    typedef struct packed {
        logic [31:0]      value;
        logic [TAG_W-1:0] tag;
    } expect_t;

    logic             clk;
    logic             rst_n;
    logic             order;
    logic [2:0]       func3;
    logic [6:0]       func7;
    logic [31:0]      rs1;
    logic [31:0]      rs2;
    logic [TAG_W-1:0] pa_rd_in;
    logic             done;
    logic [31:0]      rd;
    logic [TAG_W-1:0] pa_rd_out;

    expect_t          exp_q[$];
    logic [31:0]      lfsr_state;
    logic [TAG_W-1:0] tag_next;
    int               issued;
    int               completed;
    int               errors;
    int               ops_mark;
    int               done_mark;
    int               err_mark;

    fpu_short #(
        .PREG_ADDR_W (TAG_W)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .order     (order),
        .func3     (func3),
        .func7     (func7),
        .rs1       (rs1),
        .rs2       (rs2),
        .pa_rd_in  (pa_rd_in),
        .done      (done),
        .rd        (rd),
        .pa_rd_out (pa_rd_out)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
        return w;
    endfunction

    // exponents around the integer range
    function automatic logic [31:0] random_float();
        logic [31:0] s;
        logic [31:0] e;
        logic [31:0] f;
        s = random_bits(1);
        e = random_bits(6) + 32'd110;
        f = random_bits(23);
        return {s[0], e[7:0], f[22:0]};
    endfunction

    function automatic logic is_nan(input logic [31:0] v);
        return (v[30:23] == 8'hff) && (v[22:0] != '0);
    endfunction

    // signed key that orders floats, zero and subnormal map to 0
    function automatic longint order_key(input logic [31:0] v);
        if (v[30:23] == 8'h00) begin
            return 0;
        end
        return v[31] ? -longint'(v[30:0]) : longint'(v[30:0]);
    endfunction

    function automatic logic [31:0] itof_ref(input logic [31:0] v);
        logic [63:0] mag;
        logic [63:0] keep;
        logic [63:0] rem;
        logic [63:0] half;
        int          msb;
        int          sh;
        if (v == '0) begin
            return '0;
        end
        mag = v[31] ? (64'h1_0000_0000 - {32'b0, v}) : {32'b0, v};
        msb = 0;
        for (int i = 0; i < 64; i++) begin
            if (mag[i]) begin
                msb = i;
            end
        end
        if (msb <= 23) begin
            keep = mag << (23 - msb);
        end else begin
            sh   = msb - 23;
            keep = mag >> sh;
            rem  = mag & ((64'd1 << sh) - 64'd1);
            half = 64'd1 << (sh - 1);
            if (rem > half || (rem == half && keep[0])) begin
                keep = keep + 64'd1;
            end
            if (keep[24]) begin
                keep = keep >> 1;
                msb  = msb + 1;
            end
        end
        return {v[31], 8'(msb + 127), keep[22:0]};
    endfunction

    function automatic logic [31:0] ftoi_ref(input logic [31:0] v);
        logic [63:0] mag;
        int          unb;
        if (is_nan(v)) begin
            return 32'h7fffffff;
        end
        unb = int'(v[30:23]) - 127;
        if (unb < 0) begin
            return '0;
        end
        if (unb >= 31) begin
            return v[31] ? 32'h80000000 : 32'h7fffffff;
        end
        mag = {40'b0, 1'b1, v[22:0]};
        mag = (unb >= 23) ? (mag << (unb - 23)) : (mag >> (23 - unb));
        return v[31] ? -mag[31:0] : mag[31:0];
    endfunction

    // integer part, one more in magnitude for a negative fraction
    function automatic logic [31:0] ffloor_ref(input logic [31:0] v);
        logic [63:0] sig;
        logic [63:0] ip;
        int          fbits;
        if (v[30:23] >= 8'd150) begin
            return v;
        end
        if (v[30:23] == 8'h00) begin
            return {v[31], 31'b0};
        end
        if (v[30:23] < 8'd127) begin
            return v[31] ? 32'hbf800000 : 32'h00000000;
        end
        fbits = 150 - int'(v[30:23]);
        sig   = {40'b0, 1'b1, v[22:0]};
        ip    = sig >> fbits;
        if (v[31] && ((sig & ((64'd1 << fbits) - 64'd1)) != '0)) begin
            ip = ip + 64'd1;
        end
        return v[31] ? itof_ref(-ip[31:0]) : itof_ref(ip[31:0]);
    endfunction

    function automatic logic [31:0] fpu_ref(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [31:0] a, input logic [31:0] b);
        longint ka;
        longint kb;
        ka = order_key(a);
        kb = order_key(b);
        case (f7)
            F7_FSGNJ: begin
                case (f3)
                    3'b000:  return {b[31], a[30:0]};
                    3'b001:  return {~b[31], a[30:0]};
                    3'b010:  return {a[31] ^ b[31], a[30:0]};
                    default: return '0;
                endcase
            end
            F7_FCOMP: begin
                if (is_nan(a) || is_nan(b)) begin
                    return '0;
                end
                case (f3)
                    3'b010:  return {31'b0, ka == kb};
                    3'b001:  return {31'b0, ka < kb};
                    3'b000:  return {31'b0, ka <= kb};
                    default: return '0;
                endcase
            end
            F7_ITOF:          return itof_ref(a);
            F7_FTOI:          return ftoi_ref(a);
            F7_FRM:           return (f3 == F3_FFLOOR) ? ffloor_ref(a) : '0;
            F7_FMVI, F7_IMVF: return a;
            default:          return '0;
        endcase
    endfunction

    task automatic issue(input logic [9:0] op, input logic [31:0] a, input logic [31:0] b);
        expect_t e;
        @(posedge clk);
        order    <= 1'b1;
        func7    <= op[9:3];
        func3    <= op[2:0];
        rs1      <= a;
        rs2      <= b;
        pa_rd_in <= tag_next;
        e.value  = fpu_ref(op[9:3], op[2:0], a, b);
        e.tag    = tag_next;
        exp_q.push_back(e);
        tag_next = tag_next + 1'b1;
        issued++;
    endtask

    task automatic start_test();
        ops_mark  = issued;
        done_mark = completed;
        err_mark  = errors;
    endtask

    task automatic end_test(input string name);
        int waited;
        waited = 0;
        @(posedge clk);
        order <= 1'b0;
        // the last result is due two cycles after its order
        while (exp_q.size() != 0 && waited < 4) begin
            @(posedge clk);
            waited++;
        end
        assert (completed - done_mark == issued - ops_mark) else begin
            $display("%0t: only %0d dones arrived for %0d orders", $time,
                     completed - done_mark, issued - ops_mark);
            errors++;
        end
        $display("%s: %0d operations, %0d errors", name, issued - ops_mark, errors - err_mark);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: results still missing after %0d ns", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        expect_t e;
        if (rst_n && done) begin
            if (exp_q.size() == 0) begin
                $display("%0t: done raised with no operation outstanding", $time);
                errors++;
            end else begin
                e = exp_q.pop_front();
                completed++;
                assert (rd == e.value) else begin
                    $display("FAIL %0t: rd is %h, expected %h", $time, rd, e.value);
                    errors++;
                end
                assert (pa_rd_out == e.tag) else begin
                    $display("FAIL %0t: tag is %0d, expected %0d", $time, pa_rd_out, e.tag);
                    errors++;
                end
            end
        end
    end

    initial begin
        logic [31:0] a;
        logic [6:0]  f7;
        lfsr_state = SEED;
        tag_next   = '0;
        issued     = 0;
        completed  = 0;
        errors     = 0;
        rst_n      = 1'b0;
        order      = 1'b0;
        func3      = '0;
        func7      = '0;
        rs1        = '0;
        rs2        = '0;
        pa_rd_in   = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        start_test();
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < N_RAND; i++) begin
                issue(OP_CODE[k], random_bits(32), random_bits(32));
            end
            for (int i = 0; i < 16; i++) begin
                issue(OP_CODE[k], SPECIAL[i], SPECIAL[15 - i]);
            end
        end
        end_test("sign injection");

        // random pairs are equal half of the time
        start_test();
        for (int k = 3; k < 6; k++) begin
            for (int i = 0; i < N_RAND; i++) begin
                a = random_float();
                issue(OP_CODE[k], a, (random_bits(1) != 0) ? a : random_float());
            end
            for (int i = 0; i < 16; i++) begin
                issue(OP_CODE[k], SPECIAL[i], SPECIAL[i ^ 1]);
                issue(OP_CODE[k], SPECIAL[i], SPECIAL[15 - i]);
            end
        end
        end_test("compare");

        start_test();
        for (int i = 0; i < N_RAND; i++) begin
            a = random_bits(32);
            issue(OP_CODE[6], a, 32'h0);
            issue(OP_CODE[6], $signed(a) >>> random_bits(5), 32'h0);
        end
        for (int i = 0; i < 6; i++) begin
            issue(OP_CODE[6], INT_SPECIAL[i], 32'h0);
        end
        end_test("itof");

        start_test();
        for (int k = 7; k < 9; k++) begin
            for (int i = 0; i < N_RAND; i++) begin
                issue(OP_CODE[k], random_float(), 32'h0);
            end
            for (int i = 0; i < 16; i++) begin
                issue(OP_CODE[k], SPECIAL[i], 32'h0);
            end
        end
        end_test("ftoi and ffloor");

        start_test();
        for (int i = 0; i < N_RAND; i++) begin
            issue(OP_CODE[9], random_bits(32), random_bits(32));
            issue(OP_CODE[10], random_bits(32), random_bits(32));
            f7 = 7'(random_bits(7));
            while (f7 inside {F7_FSGNJ, F7_FCOMP, F7_FTOI, F7_ITOF, F7_FMVI, F7_IMVF, F7_FRM}) begin
                f7 = 7'(random_bits(7));
            end
            issue({f7, 3'(random_bits(3))}, random_float(), random_float());
        end
        for (int f = 0; f < 8; f++) begin
            if (3'(f) != F3_FFLOOR) begin
                issue({F7_FRM, 3'(f)}, random_float(), 32'h0);
            end
        end
        issue({F7_FSGNJ, 3'b011}, random_float(), random_float());
        issue({F7_FCOMP, 3'b011}, random_float(), random_float());
        end_test("moves and unknown operations");

        start_test();
        for (int i = 0; i < N_B2B; i++) begin
            a = (random_bits(1) != 0) ? random_float() : random_bits(32);
            issue(OP_CODE[int'(random_bits(4)) % 11], a, random_float());
        end
        end_test("back-to-back issue");

        if (exp_q.size() != 0) begin
            $display("%0d operations never produced a done", exp_q.size());
            errors++;
        end
        $display("summary: %0d operations, %0d checked, %0d errors", issued, completed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== fpu_short.f ====
hw/fpu_short_pkg.sv
hw/fpu_short_decode.sv
hw/fpu_sign_compare.sv
hw/fpu_convert.sv
hw/fpu_short_execute.sv
hw/fpu_short.sv
sim/fpu_short_assert.sv
sim/fpu_short_tb.sv

// ==== Makefile ====
# Verilator build and run of the short FPU testbench

VERILATOR ?= verilator
TOP       ?= fpu_short_tb
FILELIST  ?= fpu_short.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# the pass line in the log decides the status
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
